// ==== Makefile ====
# Verilator flow for the cache testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= cache_system_tb
RTL_TOP   ?= cache_system
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+include
source/cache_pkg.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache_lru.sv
source/cache_controller.sv
source/main_memory.sv
source/cache_system.sv
verification/cache_properties.sv
verification/cache_system_tb.sv

// ==== include/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address and data widths
`define CACHE_ADDR_W    32
`define CACHE_WORD_W    32
`define CACHE_LINE_W    128

// geometry: 2 sets of 2 ways, 16-byte lines
`define CACHE_SETS      2
`define CACHE_WAYS      2
`define CACHE_INDEX_W   1       // address bit 4
`define CACHE_OFFSET_W  4       // byte offset inside a line, bits 3 to 0
`define CACHE_TAG_W     27      // address bits 31 to 5

// backing memory
`define MEM_LINES       64      // indexed by the low line-address bits
`define MEM_LATENCY     4       // cycles from request to done pulse

`endif

// ==== source/cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_controller import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // cpu side
    input  logic       cpu_valid,
    input  logic       cpu_write,
    input  addr_t      cpu_addr,
    input  word_t      cpu_wdata,
    output word_t      cpu_rdata,
    output logic       cpu_ready,
    // tag and data arrays
    output index_t     index,
    output way_t       way,
    output logic       tag_we,
    output logic       valid_in,
    output logic       dirty_in,
    output tag_t       tag_in,
    input  logic [1:0] valid,
    input  logic [1:0] dirty,
    input  tag_t       tag_way0,
    input  tag_t       tag_way1,
    output logic       data_we,
    output line_t      data_wline,
    input  line_t      line_way0,
    input  line_t      line_way1,
    // replacement
    output logic       lru_touch,
    output way_t       touched_way,
    input  way_t       victim_way,
    // main memory
    output logic       mem_valid,
    output logic       mem_write,
    output addr_t      mem_addr,
    output line_t      mem_wdata,
    input  line_t      mem_rdata,
    input  logic       mem_ready
);

    localparam int WORD_SEL_W = $clog2(`CACHE_LINE_W / `CACHE_WORD_W);

    cache_state_t state_q, state_d;
    way_t         victim_q;          // way chosen for the current miss

    tag_t                  req_tag;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  hit0, hit1, hit;
    way_t                  hit_way;
    line_t                 hit_line;
    line_t                 merged_line;
    line_t                 victim_line;
    tag_t                  victim_tag;

    // address fields, held stable by the cpu
    assign req_tag  = cpu_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign index    = cpu_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word_sel = cpu_addr[`CACHE_OFFSET_W-1 -: WORD_SEL_W];

    assign hit0    = valid[0] && (tag_way0 == req_tag);
    assign hit1    = valid[1] && (tag_way1 == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = way_t'(hit1);

    assign hit_line    = hit1 ? line_way1 : line_way0;
    assign victim_line = victim_q ? line_way1 : line_way0;
    assign victim_tag  = victim_q ? tag_way1 : tag_way0;

    // word read out and store merge
    assign cpu_rdata = hit_line[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

    always_comb begin
        merged_line = hit_line;
        merged_line[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] = cpu_wdata;
    end

    // arrays see the hit way while comparing, the victim otherwise
    assign way         = (state_q == state_compare) ? hit_way : victim_q;
    assign touched_way = hit_way;
    assign tag_in      = req_tag;
    assign valid_in    = 1'b1;

    // memory request, line aligned
    assign mem_valid = (state_q == state_write_back) || (state_q == state_allocate);
    assign mem_write = (state_q == state_write_back);
    assign mem_wdata = victim_line;
    assign mem_addr  = (state_q == state_write_back)
                     ? {victim_tag, index, {`CACHE_OFFSET_W{1'b0}}}
                     : {req_tag, index, {`CACHE_OFFSET_W{1'b0}}};

    always_comb begin
        state_d    = state_q;
        cpu_ready  = 1'b0;
        lru_touch  = 1'b0;
        tag_we     = 1'b0;
        dirty_in   = 1'b0;
        data_we    = 1'b0;
        data_wline = merged_line;
        unique case (state_q)
            state_idle: begin
                if (cpu_valid) begin
                    state_d = state_compare;
                end
            end
            state_compare: begin
                if (hit) begin
                    cpu_ready = 1'b1;
                    lru_touch = 1'b1;
                    if (cpu_write) begin
                        data_we  = 1'b1;   // merged word goes back in
                        tag_we   = 1'b1;
                        dirty_in = 1'b1;
                    end
                    state_d = state_idle;
                end else if (valid[victim_way] && dirty[victim_way]) begin
                    state_d = state_write_back;
                end else begin
                    state_d = state_allocate;
                end
            end
            state_write_back: begin
                if (mem_ready) begin
                    state_d = state_allocate;
                end
            end
            state_allocate: begin
                if (mem_ready) begin
                    data_we    = 1'b1;   // refill, line is clean
                    data_wline = mem_rdata;
                    tag_we     = 1'b1;
                    state_d    = state_compare;
                end
            end
            default: state_d = state_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= state_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == state_compare && !hit) begin
            victim_q <= victim_way;
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_data_array import cache_pkg::*; (
    input  logic   clk,
    input  index_t index,
    input  way_t   way,
    input  logic   data_we,
    input  line_t  data_wline,
    output line_t  line_way0,
    output line_t  line_way1
);

    line_t line_mem [`CACHE_SETS][`CACHE_WAYS];

    // lines start out as zero
    initial begin
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                line_mem[s][w] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            line_mem[index][way] <= data_wline;   // one way per write
        end
    end

    assign line_way0 = line_mem[index][0];
    assign line_way1 = line_mem[index][1];

endmodule

`default_nettype wire

// ==== source/cache_lru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_lru import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  index_t     index,
    input  logic       lru_touch,
    input  way_t       touched_way,
    input  logic [1:0] valid,
    output way_t       victim_way
);

    // per set, the way that was used least recently
    logic [`CACHE_SETS-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (lru_touch) begin
            lru_q[index] <= ~touched_way;   // the other way is now oldest
        end
    end

    // empty ways are filled first
    always_comb begin
        if (!valid[0]) begin
            victim_way = way_t'(0);
        end else if (!valid[1]) begin
            victim_way = way_t'(1);
        end else begin
            victim_way = lru_q[index];
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]        addr_t;    // byte address
    typedef logic [`CACHE_WORD_W-1:0]        word_t;    // cpu word
    typedef logic [`CACHE_LINE_W-1:0]        line_t;    // one cache line
    typedef logic [`CACHE_TAG_W-1:0]         tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]       index_t;   // set number
    typedef logic [$clog2(`CACHE_WAYS)-1:0]  way_t;

    // controller states
    typedef enum logic [1:0] {
        state_idle,
        state_compare,
        state_write_back,
        state_allocate
    } cache_state_t;

endpackage

`default_nettype wire

// ==== source/cache_system.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_system import cache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cpu_valid,
    input  logic  cpu_write,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    output word_t cpu_rdata,
    output logic  cpu_ready
);

    // array interface
    index_t     index;
    way_t       way;
    logic       tag_we;
    logic       valid_in;
    logic       dirty_in;
    tag_t       tag_in;
    logic [1:0] valid;
    logic [1:0] dirty;
    tag_t       tag_way0;
    tag_t       tag_way1;
    logic       data_we;
    line_t      data_wline;
    line_t      line_way0;
    line_t      line_way1;

    // replacement
    logic       lru_touch;
    way_t       touched_way;
    way_t       victim_way;

    // memory bus
    logic       mem_valid;
    logic       mem_write;
    addr_t      mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_ready;

    cache_controller u_controller (
        .clk        (clk),
        .reset      (reset),
        .cpu_valid  (cpu_valid),
        .cpu_write  (cpu_write),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .cpu_ready  (cpu_ready),
        .index      (index),
        .way        (way),
        .tag_we     (tag_we),
        .valid_in   (valid_in),
        .dirty_in   (dirty_in),
        .tag_in     (tag_in),
        .valid      (valid),
        .dirty      (dirty),
        .tag_way0   (tag_way0),
        .tag_way1   (tag_way1),
        .data_we    (data_we),
        .data_wline (data_wline),
        .line_way0  (line_way0),
        .line_way1  (line_way1),
        .lru_touch  (lru_touch),
        .touched_way(touched_way),
        .victim_way (victim_way),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    cache_tag_array u_tag_array (
        .clk     (clk),
        .reset   (reset),
        .index   (index),
        .way     (way),
        .tag_we  (tag_we),
        .valid_in(valid_in),
        .dirty_in(dirty_in),
        .tag_in  (tag_in),
        .valid   (valid),
        .dirty   (dirty),
        .tag_way0(tag_way0),
        .tag_way1(tag_way1)
    );

    cache_data_array u_data_array (
        .clk       (clk),
        .index     (index),
        .way       (way),
        .data_we   (data_we),
        .data_wline(data_wline),
        .line_way0 (line_way0),
        .line_way1 (line_way1)
    );

    cache_lru u_lru (
        .clk        (clk),
        .reset      (reset),
        .index      (index),
        .lru_touch  (lru_touch),
        .touched_way(touched_way),
        .valid      (valid),
        .victim_way (victim_way)
    );

    main_memory u_memory (
        .clk      (clk),
        .reset    (reset),
        .mem_valid(mem_valid),
        .mem_write(mem_write),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready)
    );

endmodule

`default_nettype wire

// ==== source/cache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_tag_array import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  index_t     index,
    input  way_t       way,
    input  logic       tag_we,
    input  logic       valid_in,
    input  logic       dirty_in,
    input  tag_t       tag_in,
    output logic [1:0] valid,
    output logic [1:0] dirty,
    output tag_t       tag_way0,
    output tag_t       tag_way1
);

    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    tag_t                   tag_q   [`CACHE_SETS][`CACHE_WAYS];

    // status bits, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (tag_we) begin
            valid_q[index][way] <= valid_in;   // only the addressed way
            dirty_q[index][way] <= dirty_in;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_q[index][way] <= tag_in;
        end
    end

    // both ways read out by set
    assign valid    = valid_q[index];
    assign dirty    = dirty_q[index];
    assign tag_way0 = tag_q[index][0];
    assign tag_way1 = tag_q[index][1];

endmodule

`default_nettype wire

// ==== source/main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module main_memory import cache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  mem_valid,
    input  logic  mem_write,
    input  addr_t mem_addr,
    input  line_t mem_wdata,
    output line_t mem_rdata,
    output logic  mem_ready
);

    localparam int MEM_IDX_W = $clog2(`MEM_LINES);
    localparam int CNT_W     = $clog2(`MEM_LATENCY + 1);

    line_t                 mem [`MEM_LINES];
    logic [MEM_IDX_W-1:0]  line_idx;
    logic [CNT_W-1:0]      lat_cnt;
    logic                  access;

    initial begin
        for (int i = 0; i < `MEM_LINES; i++) begin
            mem[i] = '0;
        end
    end

    assign line_idx = mem_addr[`CACHE_OFFSET_W +: MEM_IDX_W];   // low line-address bits

    // count ends; the ready cycle itself never restarts a request
    assign access = mem_valid && !mem_ready && (lat_cnt == CNT_W'(`MEM_LATENCY));

    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt   <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= access;
            if (access) begin
                lat_cnt <= '0;
            end else if (mem_valid && !mem_ready) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (mem_write) begin
                mem[line_idx] <= mem_wdata;
            end
            mem_rdata <= mem[line_idx];   // valid with the ready pulse
        end
    end

endmodule

`default_nettype wire

// ==== verification/cache_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
    input logic clk,
    input logic reset,
    input logic cpu_valid,
    input logic cpu_ready,
    input logic mem_valid
);

    // done pulse is a single cycle
    ready_single_cycle: assert property (
        @(posedge clk) disable iff (reset) cpu_ready |=> !cpu_ready
    ) else $error("cpu_ready stayed high for more than one cycle");

    // no done pulse without an open request
    ready_needs_valid: assert property (
        @(posedge clk) disable iff (reset) cpu_ready |-> cpu_valid
    ) else $error("cpu_ready pulsed while cpu_valid was low");

    // controller starts in idle, so no memory request
    mem_quiet_after_reset: assert property (
        @(posedge clk) reset |=> !mem_valid
    ) else $error("mem_valid high in the cycle after reset");

endmodule

bind cache_controller cache_properties u_properties (
    .clk      (clk),
    .reset    (reset),
    .cpu_valid(cpu_valid),
    .cpu_ready(cpu_ready),
    .mem_valid(mem_valid)
);

`default_nettype wire

// ==== verification/cache_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_system_tb import cache_pkg::*; ();

    localparam int max_cycles = 200 * (2 * `MEM_LATENCY + 6);
    localparam int hit_cycles = 2;     // request edge to pulse on a hit

    logic  clk;
    logic  reset;
    logic  cpu_valid;
    logic  cpu_we;
    addr_t cpu_addr;
    word_t cpu_wdata;
    word_t cpu_rdata;
    logic  cpu_ready;

    word_t       ref_mem [addr_t];     // keyed by word address
    logic [15:0] lfsr_state;
    int          cycle_count;
    int          checks;
    int          errors;

    cache_system uut (
        .clk      (clk),
        .reset    (reset),
        .cpu_valid(cpu_valid),
        .cpu_write(cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_rdata(cpu_rdata),
        .cpu_ready(cpu_ready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the cache gave no answer within %0d clock cycles", max_cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;   // taps 16, 14, 13, 11
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // memory starts as zero
    function automatic word_t model_word(input addr_t addr);
        if (ref_mem.exists(addr >> 2)) begin
            return ref_mem[addr >> 2];
        end
        return '0;
    endfunction

    task automatic check_word(input addr_t addr, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: read of 0x%08h expected 0x%08h, got 0x%08h",
                     $time, addr, expected, actual);
        end
    endtask

    task automatic check_cycles(input addr_t addr, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("MISMATCH at %0d ns: hit on 0x%08h took %0d cycles, expected %0d",
                     $time, addr, actual, expected);
        end
    endtask

    // holds the request until the pulse, then drops valid
    task automatic handshake(output int cycles, output word_t data);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_ready);
        data = cpu_rdata;
        @(posedge clk);
        #1;
        cpu_valid = 1'b0;
    endtask

    task automatic cpu_write(input addr_t addr, input word_t data);
        int    cycles;
        word_t unused;
        cpu_valid = 1'b1;
        cpu_we    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        handshake(cycles, unused);
        ref_mem[addr >> 2] = data;
    endtask

    task automatic cpu_read(input addr_t addr, output int cycles);
        word_t expected;
        word_t actual;
        expected  = model_word(addr);
        cpu_valid = 1'b1;
        cpu_we    = 1'b0;
        cpu_addr  = addr;
        cpu_wdata = '0;
        handshake(cycles, actual);
        check_word(addr, expected, actual);
    endtask

    task automatic report(input string name, input int start);
        $display("%-22s %0d errors", name, errors - start);
    endtask

    task automatic test_reset_reads();
        int cycles;
        int start;
        start = errors;
        cpu_read(32'h0000_0100, cycles);
        cpu_read(32'h0000_01F4, cycles);
        cpu_read(32'h0000_03A8, cycles);
        report("reads after reset", start);
    endtask

    task automatic test_write_read();
        int cycles;
        int start;
        start = errors;
        cpu_write(32'h0000_00D4, 32'h1234_5678);
        cpu_read(32'h0000_00D4, cycles);
        cpu_read(32'h0000_00D0, cycles);   // neighbours stay zero
        cpu_read(32'h0000_00D8, cycles);
        cpu_read(32'h0000_00DC, cycles);
        report("write then read", start);
    endtask

    task automatic test_same_set();
        addr_t a = 32'h0000_0080;   // set 0, tag 4
        addr_t b = 32'h0000_00A0;   // set 0, tag 5
        int    cycles;
        int    start;
        start = errors;
        cpu_write(a, 32'hA5A5_0001);
        cpu_write(b, 32'hB4B4_0002);
        cpu_write(a, 32'hA5A5_0003);
        for (int i = 0; i < 4; i++) begin
            cpu_read(a, cycles);
            check_cycles(a, hit_cycles, cycles);
            cpu_read(b, cycles);
            check_cycles(b, hit_cycles, cycles);
        end
        report("two tags in one set", start);
    endtask

    // set 0 holds dirty a and b, a is least recent
    task automatic test_eviction();
        int cycles;
        int start;
        start = errors;
        cpu_write(32'h0000_00C4, 32'hC3C3_0004);   // third tag pushes a out
        cpu_read(32'h0000_0080, cycles);
        cpu_read(32'h0000_00A0, cycles);
        cpu_read(32'h0000_00C4, cycles);
        cpu_read(32'h0000_00C0, cycles);
        report("lru eviction", start);
    endtask

    task automatic test_random();
        logic       is_write;
        logic [2:0] line_sel;
        logic [1:0] word_sel;
        addr_t      addr;
        word_t      data;
        int         cycles;
        int         start;
        start = errors;
        for (int i = 0; i < 150; i++) begin
            is_write = 1'(take_bits(1));
            line_sel = 3'(take_bits(3));   // index plus two tag bits
            word_sel = 2'(take_bits(2));
            addr     = addr_t'({line_sel, word_sel, 2'b00});
            if (is_write) begin
                data = take_bits(32);
                cpu_write(addr, data);
            end else begin
                cpu_read(addr, cycles);
            end
        end
        report("random traffic", start);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        cpu_valid   = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        lfsr_state  = 16'd27503;
        cycle_count = 0;
        checks      = 0;
        errors      = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_reads();
        test_write_read();
        test_same_set();
        test_eviction();
        test_random();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
